//--- rp_pkg.sv
// shared definitions for the analog i/o and register fabric
// bus request/response structs, sample types, region map, register offsets

package rp_pkg;

  //////////////////////////////////////////////////////////////
  // system bus
  //////////////////////////////////////////////////////////////

  typedef logic [31:0] sys_addr_t;  // byte address
  typedef logic [31:0] sys_data_t;  // data word

  typedef struct packed {
    sys_addr_t addr;   // bits 22:20 pick the region
    sys_data_t wdata;
    logic      wen;    // single-cycle write strobe
    logic      ren;    // single-cycle read strobe
  } sys_req_t;

  typedef struct packed {
    sys_data_t rdata;
    logic      ack;    // one cycle after the strobe
    logic      err;    // unmapped offset
  } sys_rsp_t;

  //////////////////////////////////////////////////////////////
  // analog streams
  //////////////////////////////////////////////////////////////

  typedef logic        [15:0] adc_raw_t;   // raw word, 2 lsbs unused
  typedef logic signed [13:0] smp_t;       // two's complement sample
  typedef logic signed [14:0] dac_sum_t;   // one guard bit for the sum
  typedef logic        [13:0] dac_code_t;  // offset binary, neg. slope
  typedef logic        [7:0]  pwm_duty_t;  // high cycles per 256

  localparam int unsigned NUM_CH  = 2;
  localparam int unsigned NUM_PWM = 4;

  //////////////////////////////////////////////////////////////
  // address map
  //////////////////////////////////////////////////////////////

  localparam int unsigned NUM_REGIONS = 8;
  localparam int unsigned REGION_LSB  = 20;  // region = addr[22:20]
  localparam int unsigned REGION_HK   = 0;   // housekeeping
  localparam int unsigned REGION_AMS  = 4;   // pwm registers

  localparam sys_data_t RP_ID = 32'h5250_0001;

  // offsets inside a region, addr[19:0]
  localparam logic [REGION_LSB-1:0] HK_ID_OFS   = 20'h00000;
  localparam logic [REGION_LSB-1:0] HK_LOOP_OFS = 20'h00004;
  localparam logic [REGION_LSB-1:0] AMS_PWM_OFS = 20'h00020;  // +4 per channel

endpackage

//--- rp_sys_decoder.sv
// system bus decoder
// splits the bus into eight regions, gates strobes to the addressed slave,
// muxes the slave responses and answers the unused regions itself

`timescale 1ns/1ps

module rp_sys_decoder (
  input  logic             adc_clk,
  input  logic             reset_i,
  input  rp_pkg::sys_req_t sys_req_i,   // from bus master
  output rp_pkg::sys_rsp_t sys_rsp_o,
  output rp_pkg::sys_req_t hk_req_o,    // region 0
  input  rp_pkg::sys_rsp_t hk_rsp_i,
  output rp_pkg::sys_req_t ams_req_o,   // region 4
  input  rp_pkg::sys_rsp_t ams_rsp_i
);

  import rp_pkg::*;

  localparam int unsigned REG_W = $clog2(NUM_REGIONS);

  logic [REG_W-1:0] region;      // region of the current address
  logic [REG_W-1:0] region_q;    // region of the pending access
  logic             strobe;
  logic             sel_hk;
  logic             sel_ams;
  sys_rsp_t         idle_rsp_q;  // answer for regions with no slave

  assign region  = sys_req_i.addr[REGION_LSB +: REG_W];
  assign strobe  = sys_req_i.wen | sys_req_i.ren;
  assign sel_hk  = (region == REGION_HK);
  assign sel_ams = (region == REGION_AMS);

  // shared request, strobes only to the selected slave
  always_comb
  begin
    hk_req_o      = sys_req_i;
    hk_req_o.wen  = sys_req_i.wen & sel_hk;
    hk_req_o.ren  = sys_req_i.ren & sel_hk;
    ams_req_o     = sys_req_i;
    ams_req_o.wen = sys_req_i.wen & sel_ams;
    ams_req_o.ren = sys_req_i.ren & sel_ams;
  end

  //////////////////////////////////////////////////////////////
  // pending region and idle answer
  //////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      region_q   <= '0;
      idle_rsp_q <= '0;
    end
    else
    begin
      if (strobe)
        region_q <= region;  // hold until the next access
      idle_rsp_q.ack   <= strobe & ~sel_hk & ~sel_ams;
      idle_rsp_q.rdata <= '0;   // unused regions read as zero
      idle_rsp_q.err   <= 1'b0;
    end
  end

  // response follows the access, not a later address
  always_comb
  begin
    case (region_q)
      REGION_HK:  sys_rsp_o = hk_rsp_i;
      REGION_AMS: sys_rsp_o = ams_rsp_i;
      default:    sys_rsp_o = idle_rsp_q;
    endcase
  end

  a_strobe_excl: assert property (@(posedge adc_clk) disable iff (reset_i)
    !(sys_req_i.wen && sys_req_i.ren));

  // every region, with or without a slave, answers in the next cycle
  a_ack_next: assert property (@(posedge adc_clk) disable iff (reset_i)
    strobe |=> sys_rsp_o.ack);

endmodule

//--- rp_housekeeping.sv
// housekeeping registers in region 0
// read-only identification word and the digital loopback control bit

`timescale 1ns/1ps

module rp_housekeeping (
  input  logic             adc_clk,
  input  logic             reset_i,
  input  rp_pkg::sys_req_t req_i,
  output rp_pkg::sys_rsp_t rsp_o,
  output logic             digital_loop_o  // adc samples replaced by dac values
);

  import rp_pkg::*;

  logic [REGION_LSB-1:0] ofs;
  logic                  loop_q;

  assign ofs = req_i.addr[REGION_LSB-1:0];  // offset inside region

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      loop_q <= 1'b0;  // loopback off
      rsp_o  <= '0;
    end
    else
    begin
      if (req_i.wen && (ofs == HK_LOOP_OFS))
        loop_q <= req_i.wdata[0];

      rsp_o.ack   <= req_i.wen | req_i.ren;
      rsp_o.rdata <= '0;
      rsp_o.err   <= 1'b0;
      if (req_i.wen || req_i.ren)
      begin
        case (ofs)
          HK_ID_OFS:
            if (req_i.ren)
              rsp_o.rdata <= RP_ID;  // writes here are ignored
          HK_LOOP_OFS:
            if (req_i.ren)
              rsp_o.rdata <= sys_data_t'(loop_q);
          default:
            rsp_o.err <= 1'b1;  // unmapped offset
        endcase
      end
    end
  end

  assign digital_loop_o = loop_q;

endmodule

//--- rp_adc_frontend.sv
// adc front end
// registers raw words, converts negative-slope offset binary to
// two's complement, selects dac values in digital loopback

`timescale 1ns/1ps

module rp_adc_frontend (
  input  logic                                     adc_clk,
  input  logic                                     reset_i,
  input  rp_pkg::adc_raw_t [rp_pkg::NUM_CH-1:0] adc_raw_i,
  input  logic                                     digital_loop_i,
  input  rp_pkg::smp_t     [rp_pkg::NUM_CH-1:0] loop_dat_i,  // saturated dac sums
  output rp_pkg::smp_t     [rp_pkg::NUM_CH-1:0] adc_dat_o
);

  import rp_pkg::*;

  adc_raw_t [NUM_CH-1:0] raw_q;  // input register per channel
  smp_t     [NUM_CH-1:0] conv;

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      raw_q <= '0;
    else
      raw_q <= adc_raw_i;
  end

  // top 14 bits only, bits 1:0 unused
  always_comb
  begin
    for (int ch = 0; ch < NUM_CH; ch++)
    begin
      conv[ch] = {raw_q[ch][15], ~raw_q[ch][14:2]};  // msb kept, rest inverted
      adc_dat_o[ch] = digital_loop_i ? loop_dat_i[ch] : conv[ch];
    end
  end

endmodule

//--- rp_dac_backend.sv
// dac back end
// adds generator and controller streams per channel, saturates to 14 bits
// and registers the negative-slope offset binary pin code

`timescale 1ns/1ps

module rp_dac_backend (
  input  logic                                      adc_clk,
  input  logic                                      reset_i,
  input  rp_pkg::smp_t      [rp_pkg::NUM_CH-1:0] gen_dat_i,
  input  rp_pkg::smp_t      [rp_pkg::NUM_CH-1:0] ctl_dat_i,
  output rp_pkg::smp_t      [rp_pkg::NUM_CH-1:0] dac_sat_o,   // unregistered, for loopback
  output rp_pkg::dac_code_t [rp_pkg::NUM_CH-1:0] dac_code_o
);

  import rp_pkg::*;

  dac_sum_t [NUM_CH-1:0] sum;

  //////////////////////////////////////////////////////////////
  // sum and saturation
  //////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int ch = 0; ch < NUM_CH; ch++)
    begin
      sum[ch] = dac_sum_t'(gen_dat_i[ch]) + dac_sum_t'(ctl_dat_i[ch]);  // sign extended
      if (sum[ch][14] != sum[ch][13])  // overflow into guard bit
        dac_sat_o[ch] = sum[ch][14] ? smp_t'(-8192) : smp_t'(8191);
      else
        dac_sat_o[ch] = sum[ch][13:0];
    end
  end

  // pin code, sign kept and magnitude bits inverted
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      dac_code_o <= '0;
    else
    begin
      for (int ch = 0; ch < NUM_CH; ch++)
        dac_code_o[ch] <= {dac_sat_o[ch][13], ~dac_sat_o[ch][12:0]};
    end
  end

endmodule

//--- rp_ams_regs.sv
// pwm duty registers in region 4
// four 8-bit duty values, one word per channel from AMS_PWM_OFS

`timescale 1ns/1ps

module rp_ams_regs (
  input  logic                                       adc_clk,
  input  logic                                       reset_i,
  input  rp_pkg::sys_req_t                           req_i,
  output rp_pkg::sys_rsp_t                           rsp_o,
  output rp_pkg::pwm_duty_t [rp_pkg::NUM_PWM-1:0] pwm_duty_o
);

  import rp_pkg::*;

  logic [REGION_LSB-1:0]  ofs;
  logic [NUM_PWM-1:0]     hit;     // offset matches a duty register
  pwm_duty_t [NUM_PWM-1:0] duty_q;

  assign ofs = req_i.addr[REGION_LSB-1:0];

  // word address decode, channels every 4 bytes
  always_comb
  begin
    for (int i = 0; i < NUM_PWM; i++)
      hit[i] = (ofs == AMS_PWM_OFS + REGION_LSB'(4 * i));
  end

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      duty_q <= '0;  // all outputs low
      rsp_o  <= '0;
    end
    else
    begin
      rsp_o.ack   <= req_i.wen | req_i.ren;
      rsp_o.err   <= (req_i.wen | req_i.ren) & ~|hit;  // unmapped offset
      rsp_o.rdata <= '0;
      for (int i = 0; i < NUM_PWM; i++)
      begin
        if (req_i.wen && hit[i])
          duty_q[i] <= req_i.wdata[7:0];
        if (req_i.ren && hit[i])
          rsp_o.rdata <= sys_data_t'(duty_q[i]);  // upper bits read 0
      end
    end
  end

  assign pwm_duty_o = duty_q;

endmodule

//--- rp_pwm.sv
// single pwm channel
// free-running 256-cycle period, output high while count is below duty

`timescale 1ns/1ps

module rp_pwm (
  input  logic              adc_clk,
  input  logic              reset_i,
  input  rp_pkg::pwm_duty_t duty_i,   // high cycles per period
  output logic              pwm_o
);

  import rp_pkg::*;

  pwm_duty_t cnt_q;  // period counter, wraps at 256

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      cnt_q <= '0;
      pwm_o <= 1'b0;
    end
    else
    begin
      cnt_q <= cnt_q + 1'b1;
      pwm_o <= (cnt_q < duty_i);  // duty 0 never high
    end
  end

endmodule

//--- rp_analog_top.sv
// analog i/o and register fabric top level
// bus decoder, housekeeping and pwm registers, adc and dac data paths,
// four pwm outputs, all on adc_clk

`timescale 1ns/1ps

module rp_analog_top (
  input  logic                                      adc_clk,
  input  logic                                      reset_i,
  input  rp_pkg::sys_req_t                          sys_req_i,
  output rp_pkg::sys_rsp_t                          sys_rsp_o,
  input  rp_pkg::adc_raw_t  [rp_pkg::NUM_CH-1:0]  adc_raw_i,
  input  rp_pkg::smp_t      [rp_pkg::NUM_CH-1:0]  gen_dat_i,   // generator stream
  input  rp_pkg::smp_t      [rp_pkg::NUM_CH-1:0]  ctl_dat_i,   // controller stream
  output rp_pkg::smp_t      [rp_pkg::NUM_CH-1:0]  adc_dat_o,
  output rp_pkg::dac_code_t [rp_pkg::NUM_CH-1:0]  dac_code_o,
  output logic              [rp_pkg::NUM_PWM-1:0] pwm_o
);

  import rp_pkg::*;

  sys_req_t                hk_req,  ams_req;
  sys_rsp_t                hk_rsp,  ams_rsp;
  logic                    digital_loop;
  smp_t      [NUM_CH-1:0]  dac_sat;   // loopback source
  pwm_duty_t [NUM_PWM-1:0] pwm_duty;

  //////////////////////////////////////////////////////////////
  // bus fabric
  //////////////////////////////////////////////////////////////

  rp_sys_decoder u_sys_decoder (
    .adc_clk   (adc_clk),
    .reset_i   (reset_i),
    .sys_req_i (sys_req_i),
    .sys_rsp_o (sys_rsp_o),
    .hk_req_o  (hk_req),
    .hk_rsp_i  (hk_rsp),
    .ams_req_o (ams_req),
    .ams_rsp_i (ams_rsp)
  );

  rp_housekeeping u_housekeeping (
    .adc_clk        (adc_clk),
    .reset_i        (reset_i),
    .req_i          (hk_req),
    .rsp_o          (hk_rsp),
    .digital_loop_o (digital_loop)
  );

  rp_ams_regs u_ams_regs (
    .adc_clk    (adc_clk),
    .reset_i    (reset_i),
    .req_i      (ams_req),
    .rsp_o      (ams_rsp),
    .pwm_duty_o (pwm_duty)
  );

  //////////////////////////////////////////////////////////////
  // data paths
  //////////////////////////////////////////////////////////////

  rp_adc_frontend u_adc_frontend (
    .adc_clk        (adc_clk),
    .reset_i        (reset_i),
    .adc_raw_i      (adc_raw_i),
    .digital_loop_i (digital_loop),
    .loop_dat_i     (dac_sat),
    .adc_dat_o      (adc_dat_o)
  );

  rp_dac_backend u_dac_backend (
    .adc_clk    (adc_clk),
    .reset_i    (reset_i),
    .gen_dat_i  (gen_dat_i),
    .ctl_dat_i  (ctl_dat_i),
    .dac_sat_o  (dac_sat),
    .dac_code_o (dac_code_o)
  );

  for (genvar i = 0; i < NUM_PWM; i++)
  begin : g_pwm
    rp_pwm u_pwm (
      .adc_clk (adc_clk),
      .reset_i (reset_i),
      .duty_i  (pwm_duty[i]),
      .pwm_o   (pwm_o[i])
    );
  end

endmodule

//--- tb_rp_analog_top.sv
// testbench for the analog i/o and register fabric
// table rows applied in a loop, expected values from the data path rules

`timescale 1ns/1ps

module tb_rp_analog_top;

  import rp_pkg::*;

  localparam int ACK_TIMEOUT = 16;  // cycles before a bus access is given up
  localparam int NUM_ROWS    = 10;

  typedef struct packed {
    logic [8*12-1:0]       name;
    smp_t     [NUM_CH-1:0] gen;
    smp_t     [NUM_CH-1:0] ctl;
    adc_raw_t [NUM_CH-1:0] raw;
    logic                  loop;  // loopback setting for the row
    pwm_duty_t             duty;  // channel p takes the duty of row i + p
  } row_t;

  logic                     adc_clk;
  logic                     reset_i;
  sys_req_t                 sys_req;
  sys_rsp_t                 sys_rsp;
  adc_raw_t  [NUM_CH-1:0]   adc_raw;
  smp_t      [NUM_CH-1:0]   gen_dat;
  smp_t      [NUM_CH-1:0]   ctl_dat;
  smp_t      [NUM_CH-1:0]   adc_dat;
  dac_code_t [NUM_CH-1:0]   dac_code;
  logic      [NUM_PWM-1:0]  pwm;

  row_t            rows [NUM_ROWS];
  pwm_duty_t       duty_shadow [NUM_PWM];  // last duty written per channel
  integer          seed = 32'h4e03_8b59;
  logic [8*12-1:0] cur_name;
  int              row_errs;
  int              tests_run;
  int              tests_failed;
  int              total_errs;

  rp_analog_top u_rp_analog_top (
    .adc_clk    (adc_clk),
    .reset_i    (reset_i),
    .sys_req_i  (sys_req),
    .sys_rsp_o  (sys_rsp),
    .adc_raw_i  (adc_raw),
    .gen_dat_i  (gen_dat),
    .ctl_dat_i  (ctl_dat),
    .adc_dat_o  (adc_dat),
    .dac_code_o (dac_code),
    .pwm_o      (pwm)
  );

  always #4 adc_clk = ~adc_clk;  // 8 ns period

  //////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////

  // clamp the 15-bit sum to the 14-bit range
  function automatic smp_t sat_sum(input smp_t a, input smp_t b);
    int s;
    s = int'(a) + int'(b);
    if (s > 8191)
      s = 8191;
    if (s < -8192)
      s = -8192;
    return smp_t'(s);
  endfunction

  // negative slope offset binary, full scale down to zero
  function automatic dac_code_t dac_code_exp(input smp_t v);
    return dac_code_t'(8191 - int'(v));
  endfunction

  function automatic smp_t adc_conv_exp(input adc_raw_t r);
    return smp_t'(8191 - int'(r[15:2]));  // two lsbs dropped
  endfunction

  //////////////////////////////////////////////////////////////
  // checks and bus tasks
  //////////////////////////////////////////////////////////////

  task automatic check_val(input logic [8*16-1:0] what, input logic [31:0] exp,
                           input logic [31:0] act);
    if (exp !== act)
    begin
      $display("** Error %0s %0s: expected %h, actual %h", cur_name, what, exp, act);
      row_errs++;
    end
  endtask

  // one strobe, called and returning on a falling edge
  task automatic bus_access(input logic wr, input int region, input logic [19:0] ofs,
                            input sys_data_t wdata, output sys_data_t rdata,
                            output logic err);
    int waited;
    sys_req.addr  = (sys_addr_t'(region) << REGION_LSB) | sys_addr_t'(ofs);
    sys_req.wdata = wdata;
    sys_req.wen   = wr;
    sys_req.ren   = ~wr;
    @(negedge adc_clk);
    sys_req.wen = 1'b0;
    sys_req.ren = 1'b0;
    waited      = 1;
    while (!sys_rsp.ack)
    begin
      if (waited >= ACK_TIMEOUT)
      begin
        $display("bus access to region %0d offset %h was never acknowledged", region, ofs);
        $display("Simulation finished: FAIL");
        $finish;
      end
      @(negedge adc_clk);
      waited++;
    end
    check_val("ack latency", 1, waited);
    rdata = sys_rsp.rdata;
    err   = sys_rsp.err;
  endtask

  task automatic bus_write(input int region, input logic [19:0] ofs, input sys_data_t wdata);
    sys_data_t rd;
    logic      er;
    bus_access(1'b1, region, ofs, wdata, rd, er);
    check_val("write err", 0, er);
  endtask

  task automatic bus_read(input int region, input logic [19:0] ofs, output sys_data_t rd,
                          output logic er);
    bus_access(1'b0, region, ofs, '0, rd, er);
  endtask

  task automatic start_test(input logic [8*12-1:0] name);
    cur_name = name;
    row_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    total_errs += row_errs;
    if (row_errs != 0)
    begin
      tests_failed++;
      $display("test %0s failed with %0d errors", cur_name, row_errs);
    end
    else
      $display("test %0s passed", cur_name);
  endtask

  task automatic set_row(input int i, input logic [8*12-1:0] name, input smp_t g0,
                         input smp_t g1, input smp_t c0, input smp_t c1,
                         input adc_raw_t r0, input adc_raw_t r1, input logic loop,
                         input pwm_duty_t duty);
    rows[i] = {name, g1, g0, c1, c0, r1, r0, loop, duty};
  endtask

  task automatic fill_rows();
    set_row(0, "in_range", 100, -300, 200, 50, 16'h0000, 16'hffff, 0, 0);
    set_row(1, "pos_ovf", 8000, 8191, 500, 8191, 16'h8000, 16'h7ffc, 0, 1);
    set_row(2, "neg_ovf", -8000, -8192, -500, -8192, 16'h1234, 16'hbeef, 0, 128);
    set_row(3, "full_scale", 8191, -8192, 0, 0, 16'h4003, 16'hc001, 0, 255);
    set_row(4, "loop_on", 1000, -8000, -2000, -1000, 16'h5555, 16'haaaa, 1, 255);
    set_row(5, "loop_sat", 8000, -8000, 1000, -1000, 16'h0f0f, 16'hf0f0, 1, 128);
    set_row(6, "loop_off", -42, 42, 7, -7, 16'h2468, 16'h9bdf, 0, 1);
    for (int i = 7; i < NUM_ROWS; i++)
    begin
      set_row(i, "random", smp_t'($random(seed)), smp_t'($random(seed)),
              smp_t'($random(seed)), smp_t'($random(seed)), adc_raw_t'($random(seed)),
              adc_raw_t'($random(seed)), logic'(i == 8), pwm_duty_t'($random(seed)));
    end
  endtask

  //////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////

  initial
  begin
    sys_data_t rd;
    logic      er;
    logic      loop_on;
    int        high_cnt [NUM_PWM];
    adc_clk = 1'b0;
    reset_i = 1'b1;
    sys_req = '0;
    adc_raw = '0;
    gen_dat = '0;
    ctl_dat = '0;
    loop_on = 1'b0;
    for (int p = 0; p < NUM_PWM; p++)
      duty_shadow[p] = '0;
    fill_rows();
    repeat (10) @(negedge adc_clk);  // reset over 10 rising edges
    reset_i = 1'b0;
    @(negedge adc_clk);

    start_test("reset_id");
    check_val("pwm after reset", 0, pwm);
    check_val("ack after reset", 0, sys_rsp.ack);
    bus_read(REGION_HK, HK_ID_OFS, rd, er);
    check_val("id", RP_ID, rd);
    check_val("id err", 0, er);
    end_test();

    start_test("bus_err");
    for (int r = 1; r < NUM_REGIONS; r++)
    begin
      if (r == 4 || r == 5 || r == 6)
        continue;  // regions 1, 2, 3 and 7 only
      bus_read(r, 20'h00010, rd, er);
      check_val("unused rdata", 0, rd);
      check_val("unused err", 0, er);
    end
    bus_read(REGION_HK, 20'h00010, rd, er);
    check_val("hk unmapped err", 1, er);
    bus_read(REGION_AMS, 20'h00010, rd, er);
    check_val("ams unmapped err", 1, er);
    end_test();

    for (int i = 0; i < NUM_ROWS; i++)
    begin
      start_test(rows[i].name);
      if (rows[i].loop != loop_on)
      begin
        bus_write(REGION_HK, HK_LOOP_OFS, sys_data_t'(rows[i].loop));
        bus_read(REGION_HK, HK_LOOP_OFS, rd, er);
        check_val("loop readback", rows[i].loop, rd);
        loop_on = rows[i].loop;
      end
      // duties rotate over the channels so each one sees every table value
      for (int p = 0; p < NUM_PWM; p++)
      begin
        duty_shadow[p] = rows[(i + p) % NUM_ROWS].duty;
        bus_write(REGION_AMS, AMS_PWM_OFS + 20'(4 * p), sys_data_t'(duty_shadow[p]));
        bus_read(REGION_AMS, AMS_PWM_OFS + 20'(4 * p), rd, er);
        check_val("duty readback", duty_shadow[p], rd);
        check_val("duty err", 0, er);
      end

      gen_dat = rows[i].gen;
      ctl_dat = rows[i].ctl;
      adc_raw = rows[i].raw;
      #1;
      if (loop_on)
      begin
        for (int c = 0; c < NUM_CH; c++)
          check_val("loop sample", sat_sum(gen_dat[c], ctl_dat[c]), adc_dat[c]);
      end
      @(negedge adc_clk);  // one rising edge later
      for (int c = 0; c < NUM_CH; c++)
      begin
        check_val("dac code", dac_code_exp(sat_sum(gen_dat[c], ctl_dat[c])), dac_code[c]);
        if (!loop_on)
          check_val("adc sample", adc_conv_exp(adc_raw[c]), adc_dat[c]);
      end

      // one full pwm period, well after the duty write
      for (int p = 0; p < NUM_PWM; p++)
        high_cnt[p] = 0;
      for (int k = 0; k < 256; k++)
      begin
        @(negedge adc_clk);
        for (int p = 0; p < NUM_PWM; p++)
          high_cnt[p] += pwm[p];
      end
      for (int p = 0; p < NUM_PWM; p++)
        check_val("pwm high count", duty_shadow[p], high_cnt[p]);
      end_test();
    end

    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, total_errs);
    if (total_errs == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- build.f
rp_pkg.sv
rp_sys_decoder.sv
rp_housekeeping.sv
rp_adc_frontend.sv
rp_dac_backend.sv
rp_ams_regs.sv
rp_pwm.sv
rp_analog_top.sv
tb_rp_analog_top.sv
